//--- idct_top.f
common/idct_pkg.sv
idct_engine/c_coeff_rom.sv
idct_engine/idct_engine.sv
source/block_fetch.sv
source/pixel_writer.sv
source/idct_sequencer.sv
source/idct_top.sv
sim/sram_model.sv
sim/idct_tb.sv

//--- run_sim.sh
#!/bin/bash
# build the IDCT testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module idct_tb -f idct_top.f -o idct_sim \
	|| { echo "verilator build failed"; exit 1; }

sim_output=$(./obj_dir/idct_sim) || { echo "$sim_output"; echo "simulation aborted"; exit 1; }
echo "$sim_output"

grep -qx "Result: PASSED" <<< "$sim_output" && exit 0 || exit 1

//--- sim/idct_tb.sv
`timescale 1ns/100ps

module idct_tb import idct_pkg::*; ();

localparam int LINE_WORDS = 320;
localparam int NUM_BLOCKS = 8;
localparam int CLOCK_PERIOD = 100;
localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 800 + 100;
localparam real PI = 3.14159265358979;

logic Clock;
logic Resetn;
logic start;
sram_addr_t src_base;
sram_addr_t dst_base;
sram_addr_t sram_address;
sram_data_t sram_write_data;
sram_data_t sram_read_data;
logic sram_we_n;
logic done;
logic load_we;
sram_addr_t load_addr;
sram_data_t load_data;

integer seed = 32'h7e8d_1a4f;
int value_errors = 0;
int other_errors = 0;
int starts_issued = 0;
int done_count = 0;
int blk_num = 0;
sram_addr_t cur_src;
sram_addr_t cur_dst;

coef_t blk_coefs [64];
pixel_t exp_pixels [64];

idct_top #(.LINE_WORDS(LINE_WORDS)) dut0 (
	.Clock(Clock),
	.Resetn(Resetn),
	.start_i(start),
	.src_base_i(src_base),
	.dst_base_i(dst_base),
	.sram_read_data_i(sram_read_data),
	.sram_address_o(sram_address),
	.sram_write_data_o(sram_write_data),
	.sram_we_n_o(sram_we_n),
	.done_o(done)
);

sram_model sram0 (
	.Clock(Clock),
	.address_i(sram_address),
	.write_data_i(sram_write_data),
	.we_n_i(sram_we_n),
	.read_data_o(sram_read_data),
	.load_we_i(load_we),
	.load_addr_i(load_addr),
	.load_data_i(load_data)
);

always begin
	#(CLOCK_PERIOD / 2) Clock = ~Clock;
end

function automatic blk_index_t block_index(input int row, input int col);
	return blk_index_t'(row * 8 + col);
endfunction

function automatic int round_nearest(input real x);
	if (x < 0.0) begin
		return -$rtoi(-x + 0.5);
	end
	return $rtoi(x + 0.5);
endfunction

// marker for the words around each destination row
function automatic sram_data_t marker_for(input sram_addr_t addr);
	return sram_data_t'({14'd0, addr} ^ ({14'd0, addr} >> 7)) ^ 16'h5a3c;
endfunction

// expected pixels for blk_coefs, straight from the IDCT definition
function automatic void compute_reference();
	int c_tab [64];
	int t_val [64];
	int sum;
	real scale;
	for (int k = 0; k < 8; k++) begin
		scale = (k == 0) ? $sqrt(1.0 / 8.0) : $sqrt(2.0 / 8.0);
		for (int n = 0; n < 8; n++) begin
			c_tab[block_index(k, n)] =
				round_nearest(4096.0 * scale * $cos(real'((2 * n + 1) * k) * PI / 16.0));
		end
	end
	// T = S' * C
	for (int r = 0; r < 8; r++) begin
		for (int c = 0; c < 8; c++) begin
			sum = 0;
			for (int k = 0; k < 8; k++) begin
				sum = sum + int'(blk_coefs[block_index(r, k)]) * c_tab[block_index(k, c)];
			end
			t_val[block_index(r, c)] = sum >>> 8;
		end
	end
	// S = C^T * T, then clip
	for (int r = 0; r < 8; r++) begin
		for (int c = 0; c < 8; c++) begin
			sum = 0;
			for (int k = 0; k < 8; k++) begin
				sum = sum + c_tab[block_index(k, r)] * t_val[block_index(k, c)];
			end
			sum = sum >>> 16;
			exp_pixels[block_index(r, c)] = (sum < 0) ? 8'd0 : (sum > 255) ? 8'd255 : pixel_t'(sum);
		end
	end
endfunction

function automatic void fill_dc(input coef_t dc);
	for (int r = 0; r < 8; r++) begin
		for (int c = 0; c < 8; c++) begin
			blk_coefs[block_index(r, c)] = '0;
		end
	end
	blk_coefs[block_index(0, 0)] = dc;
endfunction

function automatic void fill_random();
	for (int r = 0; r < 8; r++) begin
		for (int c = 0; c < 8; c++) begin
			blk_coefs[block_index(r, c)] = coef_t'($random(seed) % 1025);
		end
	end
endfunction

task automatic compare_pixel(input string name, input pixel_t expected, input pixel_t actual);
	if (actual !== expected) begin
		value_errors++;
		$display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
	end
endtask

task automatic check_word(input string name, input sram_data_t expected, input sram_data_t actual);
	if (actual !== expected) begin
		value_errors++;
		$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
	end
endtask

task automatic verify_strobe(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		value_errors++;
		$display("[FAIL] %0t %s expected %b got %b", $time, name, expected, actual);
	end
endtask

task automatic load_word(input sram_addr_t addr, input sram_data_t value);
	@(posedge Clock);
	load_we <= 1'b1;
	load_addr <= addr;
	load_data <= value;
endtask

// load, start, wait for done, then check the whole neighbourhood of the block
task automatic run_block(input bit extra_start);
	sram_addr_t addr;
	cur_src = 18'h00400 + sram_addr_t'(blk_num * 4096);
	cur_dst = 18'h20005 + sram_addr_t'(blk_num * 4352);
	for (int r = 0; r < 8; r++) begin
		for (int c = 0; c < 8; c++) begin
			addr = cur_src + sram_addr_t'(r * LINE_WORDS + c);
			load_word(addr, sram_data_t'(blk_coefs[block_index(r, c)]));
		end
		for (int w = -1; w < 5; w++) begin
			addr = cur_dst + sram_addr_t'(r * (LINE_WORDS / 2) + w);
			load_word(addr, marker_for(addr));
		end
	end
	compute_reference();
	@(posedge Clock);
	load_we <= 1'b0;
	start <= 1'b1;
	src_base <= cur_src;
	dst_base <= cur_dst;
	starts_issued++;
	@(posedge Clock);
	start <= 1'b0;
	if (extra_start) begin
		// lands in the fetch phase
		repeat (20) @(posedge Clock);
		start <= 1'b1;
		src_base <= cur_src + 18'h100;
		dst_base <= cur_dst + 18'h100;
		@(posedge Clock);
		start <= 1'b0;
	end
	@(negedge Clock);
	while (done !== 1'b1) begin
		@(negedge Clock);
	end
	for (int r = 0; r < 8; r++) begin
		for (int w = 0; w < 4; w++) begin
			addr = cur_dst + sram_addr_t'(r * (LINE_WORDS / 2) + w);
			check_word($sformatf("mem[%h]", addr),
				{exp_pixels[block_index(r, 2 * w)], exp_pixels[block_index(r, 2 * w + 1)]},
				sram0.mem[addr]);
		end
		addr = cur_dst + sram_addr_t'(r * (LINE_WORDS / 2) - 1);
		check_word($sformatf("mem[%h]", addr), marker_for(addr), sram0.mem[addr]);
		addr = cur_dst + sram_addr_t'(r * (LINE_WORDS / 2) + 4);
		check_word($sformatf("mem[%h]", addr), marker_for(addr), sram0.mem[addr]);
		for (int c = 0; c < 8; c++) begin
			addr = cur_src + sram_addr_t'(r * LINE_WORDS + c);
			check_word($sformatf("mem[%h]", addr), sram_data_t'(blk_coefs[block_index(r, c)]),
				sram0.mem[addr]);
		end
	end
	blk_num++;
endtask

task automatic check_all_pixels(input pixel_t expected);
	sram_addr_t addr;
	sram_data_t word;
	for (int r = 0; r < 8; r++) begin
		for (int w = 0; w < 4; w++) begin
			addr = cur_dst + sram_addr_t'(r * (LINE_WORDS / 2) + w);
			word = sram0.mem[addr];
			compare_pixel($sformatf("pixel %0d", r * 8 + 2 * w), expected, word[15:8]);
			compare_pixel($sformatf("pixel %0d", r * 8 + 2 * w + 1), expected, word[7:0]);
		end
	end
endtask

// idle means no writes and no done, every done pulse is counted
always @(negedge Clock) begin
	if (done_count >= starts_issued) begin
		verify_strobe("sram_we_n_o", 1'b1, sram_we_n);
		verify_strobe("done_o", 1'b0, done);
	end
	if (done === 1'b1) begin
		done_count++;
	end
end

initial begin
	#(WATCHDOG_CYCLES * CLOCK_PERIOD);
	$display("timeout: no result after %0d clock cycles", WATCHDOG_CYCLES);
	$display("Result: FAILED");
	$finish;
end

initial begin
	Clock = 1'b0;
	Resetn <= 1'b0;
	start <= 1'b0;
	src_base <= '0;
	dst_base <= '0;
	load_we <= 1'b0;
	load_addr <= '0;
	load_data <= '0;
	repeat (2) @(posedge Clock);
	Resetn <= 1'b1;

	fill_dc(16'sd600);
	run_block(1'b0);
	check_all_pixels(exp_pixels[0]);

	for (int b = 0; b < 5; b++) begin
		fill_random();
		run_block(b == 0);
	end

	// saturate both ways
	fill_dc(16'sd4000);
	run_block(1'b0);
	check_all_pixels(8'd255);
	fill_dc(-16'sd4000);
	run_block(1'b0);
	check_all_pixels(8'd0);

	repeat (20) @(negedge Clock);
	if (done_count != starts_issued) begin
		other_errors++;
		$display("done_o pulsed %0d times for %0d accepted starts", done_count, starts_issued);
	end
	$display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
	if (value_errors + other_errors == 0) begin
		$display("Result: PASSED");
	end else begin
		$display("Result: FAILED");
	end
	$finish;
end

endmodule

//--- sim/sram_model.sv
`timescale 1ns/100ps

module sram_model import idct_pkg::*; (
	input  logic       Clock,
	input  sram_addr_t address_i,
	input  sram_data_t write_data_i,
	input  logic       we_n_i,
	output sram_data_t read_data_o,
	input  logic       load_we_i,
	input  sram_addr_t load_addr_i,
	input  sram_data_t load_data_i
);

sram_data_t mem [2**18];

// one stage short of the latency, the reader's own register is the last edge
sram_data_t data_line [SRAM_READ_LATENCY - 1];

always @(posedge Clock) begin
	// backdoor load only while the design is idle
	if (load_we_i) begin
		mem[load_addr_i] <= load_data_i;
	end else if (!we_n_i) begin
		mem[address_i] <= write_data_i;
	end
	data_line[0] <= mem[address_i];
	for (int i = 1; i < SRAM_READ_LATENCY - 1; i++) begin
		data_line[i] <= data_line[i - 1];
	end
end

assign read_data_o = data_line[SRAM_READ_LATENCY - 2];

endmodule

//--- source/idct_top.sv
`timescale 1ns/100ps

module idct_top import idct_pkg::*; #(
	parameter int LINE_WORDS = 320
) (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       start_i,
	input  sram_addr_t src_base_i,
	input  sram_addr_t dst_base_i,
	input  sram_data_t sram_read_data_i,
	output sram_addr_t sram_address_o,
	output sram_data_t sram_write_data_o,
	output logic       sram_we_n_o,
	output logic       done_o
);

logic fetch_go;
logic engine_go;
logic write_go;
logic fetch_done;
logic engine_done;
logic write_done;
sram_addr_t src_base;
sram_addr_t dst_base;
sram_req_t fetch_req;
sram_req_t write_req;
coef_wr_t coef_wr;
blk_index_t rd_index;
pixel_t pixel;

idct_sequencer seq0 (
	.Clock(Clock),
	.Resetn(Resetn),
	.start_i(start_i),
	.src_base_i(src_base_i),
	.dst_base_i(dst_base_i),
	.fetch_req_i(fetch_req),
	.write_req_i(write_req),
	.fetch_done_i(fetch_done),
	.engine_done_i(engine_done),
	.write_done_i(write_done),
	.fetch_go_o(fetch_go),
	.engine_go_o(engine_go),
	.write_go_o(write_go),
	.src_base_o(src_base),
	.dst_base_o(dst_base),
	.sram_address_o(sram_address_o),
	.sram_write_data_o(sram_write_data_o),
	.sram_we_n_o(sram_we_n_o),
	.done_o(done_o)
);

block_fetch #(.LINE_WORDS(LINE_WORDS)) fetch0 (
	.Clock(Clock),
	.Resetn(Resetn),
	.go_i(fetch_go),
	.src_base_i(src_base),
	.sram_read_data_i(sram_read_data_i),
	.req_o(fetch_req),
	.coef_wr_o(coef_wr),
	.done_o(fetch_done)
);

idct_engine engine0 (
	.Clock(Clock),
	.Resetn(Resetn),
	.go_i(engine_go),
	.coef_wr_i(coef_wr),
	.rd_index_i(rd_index),
	.pixel_o(pixel),
	.done_o(engine_done)
);

pixel_writer #(.LINE_WORDS(LINE_WORDS)) writer0 (
	.Clock(Clock),
	.Resetn(Resetn),
	.go_i(write_go),
	.dst_base_i(dst_base),
	.pixel_i(pixel),
	.rd_index_o(rd_index),
	.req_o(write_req),
	.done_o(write_done)
);

endmodule

//--- source/idct_sequencer.sv
`timescale 1ns/100ps

module idct_sequencer import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       start_i,
	input  sram_addr_t src_base_i,
	input  sram_addr_t dst_base_i,
	input  sram_req_t  fetch_req_i,
	input  sram_req_t  write_req_i,
	input  logic       fetch_done_i,
	input  logic       engine_done_i,
	input  logic       write_done_i,
	output logic       fetch_go_o,
	output logic       engine_go_o,
	output logic       write_go_o,
	output sram_addr_t src_base_o,
	output sram_addr_t dst_base_o,
	output sram_addr_t sram_address_o,
	output sram_data_t sram_write_data_o,
	output logic       sram_we_n_o,
	output logic       done_o
);

typedef enum logic [1:0] {
	SEQ_IDLE,
	SEQ_FETCH,
	SEQ_COMPUTE,
	SEQ_WRITE
} seq_state_t;

seq_state_t state;
logic start_accept;
sram_req_t sram_req;

// starts while busy are dropped
assign start_accept = (state == SEQ_IDLE) && start_i;

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= SEQ_IDLE;
		fetch_go_o <= 1'b0;
		engine_go_o <= 1'b0;
		write_go_o <= 1'b0;
	end else begin
		fetch_go_o <= start_accept;
		engine_go_o <= (state == SEQ_FETCH) && fetch_done_i;
		write_go_o <= (state == SEQ_COMPUTE) && engine_done_i;
		case (state)
			SEQ_IDLE: begin
				if (start_i) begin
					state <= SEQ_FETCH;
				end
			end
			SEQ_FETCH: begin
				if (fetch_done_i) begin
					state <= SEQ_COMPUTE;
				end
			end
			SEQ_COMPUTE: begin
				if (engine_done_i) begin
					state <= SEQ_WRITE;
				end
			end
			SEQ_WRITE: begin
				if (write_done_i) begin
					state <= SEQ_IDLE;
				end
			end
			default: state <= SEQ_IDLE;
		endcase
	end
end

always_ff @(posedge Clock) begin
	if (start_accept) begin
		src_base_o <= src_base_i;
		dst_base_o <= dst_base_i;
	end
end

// SRAM port belongs to the active phase
always_comb begin
	case (state)
		SEQ_FETCH: sram_req = fetch_req_i;
		SEQ_WRITE: sram_req = write_req_i;
		default: sram_req = '{address: '0, write_data: '0, we_n: 1'b1};
	endcase
end

assign sram_address_o = sram_req.address;
assign sram_write_data_o = sram_req.write_data;
assign sram_we_n_o = sram_req.we_n;

assign done_o = (state == SEQ_WRITE) && write_done_i;

endmodule

//--- source/pixel_writer.sv
`timescale 1ns/100ps

module pixel_writer import idct_pkg::*; #(
	parameter int LINE_WORDS = 320
) (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       go_i,
	input  sram_addr_t dst_base_i,
	input  pixel_t     pixel_i,
	output blk_index_t rd_index_o,
	output sram_req_t  req_o,
	output logic       done_o
);

logic active;
blk_index_t rd_idx;
pixel_t even_q;
sram_addr_t row_base;
sram_addr_t wr_addr_q;
sram_data_t wr_data_q;
logic wr_en_q;

assign rd_index_o = rd_idx;

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		active <= 1'b0;
		rd_idx <= '0;
		wr_en_q <= 1'b0;
		done_o <= 1'b0;
	end else begin
		// the final write is the only one seen after active drops
		done_o <= wr_en_q && !active;
		wr_en_q <= active && rd_idx[0];
		if (go_i) begin
			active <= 1'b1;
			rd_idx <= '0;
		end else if (active) begin
			rd_idx <= rd_idx + 6'd1;
			if (rd_idx == 6'd63) begin
				active <= 1'b0;
			end
		end
	end
end

// even pixel waits a cycle for its odd neighbour
always_ff @(posedge Clock) begin
	if (go_i) begin
		row_base <= dst_base_i;
	end else if (active && rd_idx[2:0] == 3'd7) begin
		row_base <= row_base + sram_addr_t'(LINE_WORDS / 2);
	end
	if (!rd_idx[0]) begin
		even_q <= pixel_i;
	end
	wr_addr_q <= row_base + sram_addr_t'(rd_idx[2:1]);
	wr_data_q <= {even_q, pixel_i};
end

always_comb begin
	req_o.address = wr_addr_q;
	req_o.write_data = wr_data_q;
	req_o.we_n = !wr_en_q;
end

endmodule

//--- source/block_fetch.sv
`timescale 1ns/100ps

module block_fetch import idct_pkg::*; #(
	parameter int LINE_WORDS = 320
) (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       go_i,
	input  sram_addr_t src_base_i,
	input  sram_data_t sram_read_data_i,
	output sram_req_t  req_o,
	output coef_wr_t   coef_wr_o,
	output logic       done_o
);

localparam int LAST = SRAM_READ_LATENCY - 1;

logic issuing;
blk_index_t read_idx;
sram_addr_t row_addr;
sram_data_t data_q;
logic valid_line [SRAM_READ_LATENCY];
blk_index_t idx_line [SRAM_READ_LATENCY];

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		issuing <= 1'b0;
		read_idx <= '0;
		valid_line <= '{default: 1'b0};
		done_o <= 1'b0;
	end else begin
		if (go_i) begin
			issuing <= 1'b1;
			read_idx <= '0;
		end else if (issuing) begin
			read_idx <= read_idx + 6'd1;
			if (read_idx == 6'd63) begin
				issuing <= 1'b0;
			end
		end
		valid_line[0] <= issuing;
		for (int i = 1; i < SRAM_READ_LATENCY; i++) begin
			valid_line[i] <= valid_line[i - 1];
		end
		done_o <= valid_line[LAST] && (idx_line[LAST] == 6'd63);
	end
end

// tag line runs alongside the reads in flight
always_ff @(posedge Clock) begin
	if (go_i) begin
		row_addr <= src_base_i;
	end else if (issuing && read_idx[2:0] == 3'd7) begin
		row_addr <= row_addr + sram_addr_t'(LINE_WORDS);
	end
	idx_line[0] <= read_idx;
	for (int i = 1; i < SRAM_READ_LATENCY; i++) begin
		idx_line[i] <= idx_line[i - 1];
	end
	data_q <= sram_read_data_i;
end

always_comb begin
	req_o.address = row_addr + sram_addr_t'(read_idx[2:0]);
	req_o.write_data = '0;
	req_o.we_n = 1'b1;
	coef_wr_o.valid = valid_line[LAST];
	coef_wr_o.index = idx_line[LAST];
	coef_wr_o.coef = coef_t'(data_q);
end

endmodule

//--- idct_engine/idct_engine.sv
`timescale 1ns/100ps

module idct_engine import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       go_i,
	input  coef_wr_t   coef_wr_i,
	input  blk_index_t rd_index_i,
	output pixel_t     pixel_o,
	output logic       done_o
);

typedef enum logic [1:0] {
	ENG_IDLE,
	ENG_ROW,
	ENG_COL
} engine_state_t;

engine_state_t state;
blk_index_t out_idx;
logic [1:0] step;

// S', T and S
coef_t coef_buf [64];
acc_t t_buf [64];
pixel_t pix_buf [64];

logic [2:0] out_row;
logic [2:0] out_col;
logic [2:0] k0;
logic [2:0] k1;
logic [2:0] n_sel;
c_coef_t c0;
c_coef_t c1;
acc_t op0;
acc_t op1;
acc_t prod0;
acc_t prod1;
acc_t acc;
acc_t sum;
acc_t row_scaled;
acc_t col_scaled;
pixel_t clipped;
logic last_step;
logic last_out;

assign out_row = out_idx[5:3];
assign out_col = out_idx[2:0];
assign k0 = {step, 1'b0};
assign k1 = {step, 1'b1};
assign last_step = (step == 2'd3);
assign last_out = (out_idx == 6'd63);

// row pass indexes C by output column, column pass by output row
assign n_sel = (state == ENG_COL) ? out_row : out_col;

c_coeff_rom rom0 (
	.k0_i(k0),
	.n0_i(n_sel),
	.k1_i(k1),
	.n1_i(n_sel),
	.c0_o(c0),
	.c1_o(c1)
);

always_comb begin
	if (state == ENG_COL) begin
		op0 = t_buf[{k0, out_col}];
		op1 = t_buf[{k1, out_col}];
	end else begin
		op0 = acc_t'(coef_buf[{out_row, k0}]);
		op1 = acc_t'(coef_buf[{out_row, k1}]);
	end
end

assign prod0 = op0 * acc_t'(c0);
assign prod1 = op1 * acc_t'(c1);
assign sum = ((step == 2'd0) ? acc_t'(0) : acc) + prod0 + prod1;
assign row_scaled = sum >>> 8;
assign col_scaled = sum >>> 16;

always_comb begin
	if (col_scaled < 0) begin
		clipped = 8'd0;
	end else if (col_scaled > 255) begin
		clipped = 8'd255;
	end else begin
		clipped = col_scaled[7:0];
	end
end

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= ENG_IDLE;
		out_idx <= '0;
		step <= '0;
		done_o <= 1'b0;
	end else begin
		done_o <= 1'b0;
		case (state)
			ENG_IDLE: begin
				out_idx <= '0;
				step <= '0;
				if (go_i) begin
					state <= ENG_ROW;
				end
			end
			ENG_ROW, ENG_COL: begin
				step <= step + 2'd1;
				if (last_step) begin
					out_idx <= out_idx + 6'd1;
					if (last_out && state == ENG_ROW) begin
						state <= ENG_COL;
					end else if (last_out) begin
						state <= ENG_IDLE;
						done_o <= 1'b1;
					end
				end
			end
			default: state <= ENG_IDLE;
		endcase
	end
end

// four cycles per entry, stored on the fourth
always_ff @(posedge Clock) begin
	if (coef_wr_i.valid) begin
		coef_buf[coef_wr_i.index] <= coef_wr_i.coef;
	end
	acc <= sum;
	if (last_step && state == ENG_ROW) begin
		t_buf[out_idx] <= row_scaled;
	end
	if (last_step && state == ENG_COL) begin
		pix_buf[out_idx] <= clipped;
	end
end

assign pixel_o = pix_buf[rd_index_i];

endmodule

//--- idct_engine/c_coeff_rom.sv
`timescale 1ns/100ps

module c_coeff_rom import idct_pkg::*; (
	input  logic [2:0] k0_i,
	input  logic [2:0] n0_i,
	input  logic [2:0] k1_i,
	input  logic [2:0] n1_i,
	output c_coef_t    c0_o,
	output c_coef_t    c1_o
);

// n = 0..3 of each row k, the rest is mirrored
localparam c_coef_t C_HALF [8][4] = '{
	'{1448,  1448,  1448,  1448},
	'{2009,  1703,  1138,   400},
	'{1892,   784,  -784, -1892},
	'{1703,  -400, -2009, -1138},
	'{1448, -1448, -1448,  1448},
	'{1138, -2009,   400,  1703},
	'{ 784, -1892,  1892,  -784},
	'{ 400, -1138,  1703, -2009}
};

function automatic c_coef_t lookup(input logic [2:0] k, input logic [2:0] n);
	logic [1:0] col;
	c_coef_t entry;
	// 7 - n for the upper half
	col = n[1:0] ^ {2{n[2]}};
	entry = C_HALF[k][col];
	// odd rows flip sign across the middle
	if (n[2] && k[0]) begin
		entry = -entry;
	end
	return entry;
endfunction

assign c0_o = lookup(k0_i, n0_i);
assign c1_o = lookup(k1_i, n1_i);

endmodule

//--- common/idct_pkg.sv
package idct_pkg;

	// SRAM side
	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;

	// block data
	typedef logic signed [15:0] coef_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [7:0] pixel_t;

	// row * 8 + column
	typedef logic [5:0] blk_index_t;

	// cosine table entry, scaled by 4096
	typedef logic signed [15:0] c_coef_t;

	// edges from address to the edge that samples its data
	localparam int SRAM_READ_LATENCY = 2;

	// one SRAM access for one cycle
	typedef struct packed {
		sram_addr_t address;
		sram_data_t write_data;
		logic we_n;
	} sram_req_t;

	// one write into the coefficient buffer
	typedef struct packed {
		logic valid;
		blk_index_t index;
		coef_t coef;
	} coef_wr_t;

endpackage
